//--- filelist.f
gps_cfg_pkg.sv
gps_host_pkg.sv
gps_tick_timer.sv
gps_serial_shifter.sv
gps_sampler.sv
gps_corr_chan.sv
gps_host_fsm.sv
gps_rx_top.sv
gps_rx_tb.sv

//--- gps_rx_tb.sv
// Receiver control testbench
`timescale 1ns/100ps

module gps_rx_tb;
    import gps_cfg_pkg::*;
    import gps_host_pkg::*;

    localparam int SAMPLE_BITS = 32;
    // Over three code periods
    localparam int SETTLE = 3 * CODE_LEN + 7;
    localparam int PAUSE_TICKS = 300;
    localparam int MAX_STALL = 3;
    // Maximal code has one more one than zeros per period
    localparam int CODE_ONES = (CODE_LEN + 1) / 2;
    localparam int CODE_ZEROS = CODE_LEN / 2;
    // Longest read is six words with stalls and command overhead
    localparam int READ_CYCLES = 6 * (16 + 3 + MAX_STALL) + 4;
    localparam int TEST_CYCLES = (SAMPLE_BITS + 3 * READ_CYCLES)
                               + 2 * (SETTLE + 8 * READ_CYCLES)
                               + (2 * CODE_LEN + 2 * READ_CYCLES)
                               + 2 * READ_CYCLES
                               + (2 * SETTLE + PAUSE_TICKS + 8 * READ_CYCLES);
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic     clk;
    logic     rst;
    gps_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    gps_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    logic     sample_in;
    logic     host_srq;

    int cyc = 0;
    int n_checks = 0;
    int n_errors = 0;
    int test_errors = 0;
    int n_words = 0;
    // Edge at which the channels restarted with the sampler
    int rst_edge = 0;
    logic [31:0] lcg_state;
    gps_rsp_t rsp_buf [8];

    gps_rx_top uut (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .sample_in (sample_in),
        .host_srq  (host_srq)
    );

    always #5 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cyc);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_bit(output logic b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[31];
    endtask

    task automatic check_rsp(input string what, input gps_rsp_t got, input gps_rsp_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s, data %h last %b, expected data %h last %b",
                     $time, what, got.data, got.last, exp.data, exp.last);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic check_srq(input string what, input gps_srq_t got, input gps_srq_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s, host %b chan %b, expected host %b chan %b",
                     $time, what, got.host, got.chan, exp.host, exp.chan);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        n_checks++;
        if (ok !== 1'b1)
        begin
            $display("Fail at %0t ns: %s", $time, what);
            n_errors++;
            test_errors++;
        end
    endtask

    // All driving happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            next_cycle();
        end
    endtask

    task automatic send_cmd(input gps_op_e op, input logic [15:0] arg);
        cmd.op    = op;
        cmd.arg   = arg;
        cmd_valid = 1'b1;
        // cmd_ready comes from the state register and is stable mid-cycle
        while (!cmd_ready)
        begin
            next_cycle();
        end
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    // Collects words until last with random stalls on rsp_ready
    task automatic collect_rsp();
        logic go;
        logic done;
        int   stall;
        n_words = 0;
        stall   = 0;
        done    = 1'b0;
        while (!done)
        begin
            rand_bit(go);
            // Stalls capped at MAX_STALL cycles per word
            if (stall >= MAX_STALL)
            begin
                go = 1'b1;
            end
            rsp_ready = go;
            if (rsp_valid && go)
            begin
                rsp_buf[n_words] = rsp;
                n_words++;
                done  = rsp.last || n_words >= 8;
                stall = 0;
            end
            else if (rsp_valid)
            begin
                stall++;
            end
            next_cycle();
        end
        rsp_ready = 1'b0;
    endtask

    task automatic do_read(input gps_op_e op);
        send_cmd(op, 16'h0000);
        collect_rsp();
    endtask

    task automatic check_word(input string what, input logic [15:0] exp_data);
        check_true(n_words == 1, $sformatf("%s gave %0d words instead of one", what, n_words));
        check_rsp(what, rsp_buf[0], '{data: exp_data, last: 1'b1});
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////
    // Directed tests

    task automatic test_sampler_packing();
        logic [SAMPLE_BITS-1:0] bits;
        logic b;
        send_cmd(SAMPLER_RST, 16'h0000);
        // Sampler and free channels restart on the next edge
        // That edge takes the first bit
        rst_edge = cyc + 1;
        for (int i = 0; i < SAMPLE_BITS; i++)
        begin
            rand_bit(b);
            bits[SAMPLE_BITS-1-i] = b;
            sample_in = b;
            next_cycle();
        end
        // Later words fill with zeros
        sample_in = 1'b0;
        do_read(GET_SAMPLES);
        check_word("first sample word", bits[31:16]);
        do_read(GET_SAMPLES);
        check_word("second sample word", bits[15:0]);
        do_read(GET_SAMPLES);
        check_word("third sample word", 16'h0000);
        end_test("sampler packing");
    endtask

    task automatic test_match_count();
        logic [15:0] exp;
        for (int v = 1; v >= 0; v--)
        begin
            sample_in = v[0];
            exp = v ? 16'(CODE_ONES) : 16'(CODE_ZEROS);
            wait_cycles(SETTLE);
            for (int ch = 0; ch < GPS_CHANS; ch++)
            begin
                send_cmd(SET_CHAN, 16'(ch));
                do_read(GET_CHAN);
                check_word($sformatf("channel %0d count, sample %0d", ch, v), exp);
            end
        end
        end_test("match count");
    endtask

    task automatic test_noted_requests();
        gps_srq_t exp;
        gps_srq_t got;
        send_cmd(SET_MASK, 16'b1010);
        wait_cycles(CODE_LEN + 2);
        host_srq = 1'b1;
        wait_cycles(2);
        host_srq = 1'b0;
        // Channels share one phase
        // Start just after an epoch so both reads fit before the next one
        while ((cyc - rst_edge) % CODE_LEN != 1)
        begin
            next_cycle();
        end
        do_read(GET_SRQ);
        exp = '{host: 1'b1, chan: 4'b1010};
        got = rsp_buf[0].data[15 -: SRQ_BITS];
        check_true(n_words == 1, $sformatf("first GET_SRQ gave %0d words", n_words));
        check_srq("noted requests", got, exp);
        check_rsp("request word", rsp_buf[0], '{data: {exp, 11'h000}, last: 1'b1});
        do_read(GET_SRQ);
        exp = '0;
        got = rsp_buf[0].data[15 -: SRQ_BITS];
        check_true(n_words == 1, $sformatf("second GET_SRQ gave %0d words", n_words));
        check_srq("requests after restart", got, exp);
        check_rsp("cleared request word", rsp_buf[0], '{data: 16'h0000, last: 1'b1});
        end_test("noted requests");
    endtask

    task automatic test_snapshot_framing();
        logic [TICK_BITS-1:0] t_first;
        logic [TICK_BITS-1:0] t_now;
        t_first = '0;
        for (int k = 0; k < 2; k++)
        begin
            do_read(GET_SNAPSHOT);
            check_true(n_words == 6, $sformatf("snapshot gave %0d words instead of six", n_words));
            for (int i = 0; i < 5; i++)
            begin
                check_true(!rsp_buf[i].last, $sformatf("snapshot word %0d has last set", i));
            end
            check_true(rsp_buf[5].last, "sixth snapshot word has last clear");
            check_true(rsp_buf[5].data[11:0] == 12'h000, "snapshot padding bits are not zero");
            // Ticks lead the payload
            t_now = {rsp_buf[0].data, rsp_buf[1].data, rsp_buf[2].data};
            if (k == 0)
            begin
                t_first = t_now;
            end
            else
            begin
                check_true(t_now > t_first, "second snapshot ticks are not greater than first");
            end
        end
        end_test("snapshot framing");
    endtask

    task automatic test_pause_hold();
        int pause_edge;
        send_cmd(SET_CHAN, 16'd2);
        sample_in = 1'b1;
        wait_cycles(SETTLE);
        do_read(GET_CHAN);
        check_word("channel 2 count before hold", 16'(CODE_ONES));
        send_cmd(SET_PAUSE, 16'(PAUSE_TICKS));
        // Countdown reloads on the next edge
        pause_edge = cyc + 1;
        send_cmd(HOLD_CHAN, 16'h0000);
        wait_cycles(3);
        sample_in = 1'b0;
        wait_cycles(SETTLE);
        send_cmd(SET_CHAN, 16'd0);
        do_read(GET_CHAN);
        check_word("free channel 0 count during hold", 16'(CODE_ZEROS));
        send_cmd(SET_CHAN, 16'd2);
        do_read(GET_CHAN);
        check_word("held channel 2 count", 16'(CODE_ONES));
        // Resume one cycle past the countdown underflow
        while (cyc < pause_edge + PAUSE_TICKS + 1 + SETTLE)
        begin
            next_cycle();
        end
        do_read(GET_CHAN);
        check_word("channel 2 count after resume", 16'(CODE_ZEROS));
        end_test("pause hold");
    endtask

    ////////////////////
    // Main sequence

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        cmd       = '{op: SET_CHAN, arg: 16'h0000};
        cmd_valid = 1'b0;
        rsp_ready = 1'b0;
        sample_in = 1'b0;
        host_srq  = 1'b0;
        lcg_state = 32'ha909;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_true(cmd_ready === 1'b1, "cmd_ready is not high after reset");
        check_true(rsp_valid === 1'b0, "rsp_valid is not low after reset");
        end_test("reset state");
        test_sampler_packing();
        test_match_count();
        test_noted_requests();
        test_snapshot_framing();
        test_pause_hold();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- gps_rx_top.sv
// Receiver control top level
`timescale 1ns/100ps

module gps_rx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  gps_host_pkg::gps_cmd_t cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output gps_host_pkg::gps_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    input  logic                   sample_in,
    input  logic                   host_srq
);
    import gps_cfg_pkg::*;

    logic [GPS_CHANS-1:0]       chan_srq;
    logic [GPS_CHANS-1:0][15:0] chan_count;
    logic [GPS_CHANS-1:0][GPS_REPL_BITS-1:0] replicas;
    logic [GPS_CHANS-1:0]       chan_rst;
    logic [GPS_CHANS-1:0]       chan_hold;
    logic [TICK_BITS-1:0]       ticks;
    logic [PAUSE_BITS-1:0]      pause_value;
    logic [15:0]                sample_word;
    logic srq_load;
    logic snap_load;
    logic bit_shift;
    logic srq_bit;
    logic snap_bit;
    logic sample;
    logic sample_pop;
    logic sampler_rst;
    logic pause_load;
    logic resume;
    gps_srq_t  noted;
    gps_snap_t snap;

    // Unserviced epochs include ones noted but not yet read
    assign snap = '{ticks: ticks, epochs: chan_srq | noted.chan, replicas: replicas};

    gps_host_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .chan_srq    (chan_srq),
        .host_srq    (host_srq),
        .srq_load    (srq_load),
        .snap_load   (snap_load),
        .bit_shift   (bit_shift),
        .srq_bit     (srq_bit),
        .snap_bit    (snap_bit),
        .chan_count  (chan_count),
        .sample_word (sample_word),
        .sample_pop  (sample_pop),
        .sampler_rst (sampler_rst),
        .pause_load  (pause_load),
        .pause_value (pause_value),
        .chan_rst    (chan_rst),
        .chan_hold   (chan_hold),
        .noted       (noted)
    );

    gps_tick_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .pause_load  (pause_load),
        .pause_value (pause_value),
        .ticks       (ticks),
        .resume      (resume)
    );

    ////////////////////
    // Serial readout

    gps_serial_shifter #(.payload_t(gps_srq_t)) u_srq_shift (
        .clk   (clk),
        .rst   (rst),
        .load  (srq_load),
        .shift (bit_shift),
        .din   (noted),
        .sout  (srq_bit)
    );

    gps_serial_shifter #(.payload_t(gps_snap_t)) u_snap_shift (
        .clk   (clk),
        .rst   (rst),
        .load  (snap_load),
        .shift (bit_shift),
        .din   (snap),
        .sout  (snap_bit)
    );

    gps_sampler u_sampler (
        .clk       (clk),
        .rst       (rst | sampler_rst),
        .sample_in (sample_in),
        .pop       (sample_pop),
        .sample    (sample),
        .word      (sample_word)
    );

    ////////////////////
    // Correlator channels

    for (genvar ch = 0; ch < GPS_CHANS; ch++)
    begin : g_chan
        gps_corr_chan u_chan (
            .clk     (clk),
            .rst     (rst | chan_rst[ch]),
            .sample  (sample),
            .hold    (chan_hold[ch]),
            .resume  (resume),
            .epoch   (chan_srq[ch]),
            .replica (replicas[ch]),
            .count   (chan_count[ch])
        );
    end

endmodule

//--- gps_host_fsm.sv
// Receiver command state machine
`timescale 1ns/100ps

module gps_host_fsm (
    input  logic                                     clk,
    input  logic                                     rst,
    input  gps_host_pkg::gps_cmd_t                   cmd,
    input  logic                                     cmd_valid,
    output logic                                     cmd_ready,
    output gps_host_pkg::gps_rsp_t                   rsp,
    output logic                                     rsp_valid,
    input  logic                                     rsp_ready,
    input  logic [gps_cfg_pkg::GPS_CHANS-1:0]        chan_srq,
    input  logic                                     host_srq,
    output logic                                     srq_load,
    output logic                                     snap_load,
    output logic                                     bit_shift,
    input  logic                                     srq_bit,
    input  logic                                     snap_bit,
    input  logic [gps_cfg_pkg::GPS_CHANS-1:0][15:0]  chan_count,
    input  logic [15:0]                              sample_word,
    output logic                                     sample_pop,
    output logic                                     sampler_rst,
    output logic                                     pause_load,
    output logic [gps_cfg_pkg::PAUSE_BITS-1:0]       pause_value,
    output logic [gps_cfg_pkg::GPS_CHANS-1:0]        chan_rst,
    output logic [gps_cfg_pkg::GPS_CHANS-1:0]        chan_hold,
    output gps_cfg_pkg::gps_srq_t                    noted
);
    import gps_cfg_pkg::*;
    import gps_host_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_LOAD, S_SHIFT, S_PRESENT, S_WAIT} state_e;

    state_e   state;
    gps_op_e  cur_op;
    gps_srq_t srq_now;
    gps_srq_t srq_sticky;
    logic [CHAN_SEL_BITS-1:0] chan_sel;
    logic [GPS_CHANS-1:0]     chan_mask;
    logic [READ_CNT_BITS-1:0] bit_cnt;
    logic [READ_CNT_BITS-1:0] payload_len;
    logic [15:0] word;
    logic last_word;
    logic ser_bit;
    logic accept;

    assign accept     = cmd_valid && cmd_ready;
    assign cmd_ready  = state == S_IDLE;
    assign rsp_valid  = state == S_WAIT;
    assign srq_load   = state == S_LOAD && cur_op == GET_SRQ;
    assign snap_load  = state == S_LOAD && cur_op == GET_SNAPSHOT;
    assign sample_pop = state == S_LOAD && cur_op == GET_SAMPLES;
    // Shifting stops outside the shift state, so back-pressure freezes the read
    assign bit_shift  = state == S_SHIFT;
    assign ser_bit    = (cur_op == GET_SRQ) ? srq_bit : snap_bit;
    assign payload_len = (cur_op == GET_SRQ) ? READ_CNT_BITS'(SRQ_BITS)
                                             : READ_CNT_BITS'(SNAP_BITS);

    ////////////////////
    // Channel control and write commands

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            chan_sel    <= '0;
            chan_mask   <= '0;
            sampler_rst <= 1'b0;
            pause_load  <= 1'b0;
            chan_rst    <= '0;
            chan_hold   <= '0;
        end
        else
        begin
            sampler_rst <= accept && cmd.op == SAMPLER_RST;
            pause_load  <= accept && cmd.op == SET_PAUSE;
            // Free channels restart with the sampler, so code phase counts from sampling
            chan_rst  <= (accept && cmd.op == SAMPLER_RST) ? ~chan_mask : '0;
            chan_hold <= (accept && cmd.op == HOLD_CHAN) ? GPS_CHANS'(1) << chan_sel : '0;
            if (accept && cmd.op == SET_CHAN)
            begin
                chan_sel <= cmd.arg[CHAN_SEL_BITS-1:0];
            end
            if (accept && cmd.op == SET_MASK)
            begin
                chan_mask <= cmd.arg[GPS_CHANS-1:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && cmd.op == SET_PAUSE)
        begin
            pause_value <= cmd.arg;
        end
    end

    ////////////////////
    // Sticky service requests

    assign srq_now = '{host: host_srq, chan: chan_srq};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            srq_sticky <= '0;
        end
        else if (srq_load)
        begin
            // Restart from what is pending right now
            srq_sticky <= srq_now;
        end
        else
        begin
            srq_sticky <= gps_srq_t'(srq_sticky | srq_now);
        end
    end

    // Host bit is never masked
    assign noted = '{host: srq_sticky.host, chan: srq_sticky.chan & chan_mask};

    ////////////////////
    // Read sequencing

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD:
                begin
                    bit_cnt <= '0;
                    case (cur_op)
                        GET_SRQ, GET_SNAPSHOT: state <= S_SHIFT;
                        GET_CHAN, GET_SAMPLES: state <= S_PRESENT;
                        default:               state <= S_IDLE;
                    endcase
                end
                S_SHIFT:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt[3:0] == 4'hf)
                    begin
                        state <= S_PRESENT;
                    end
                end
                S_PRESENT:
                begin
                    state <= S_WAIT;
                end
                default:
                begin
                    // Word holds until the host takes it
                    if (rsp_ready)
                    begin
                        state <= rsp.last ? S_IDLE : S_SHIFT;
                    end
                end
            endcase
        end
    end

    // Word assembly and the response register
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_op <= cmd.op;
        end
        case (state)
            S_LOAD:
            begin
                last_word <= 1'b1;
                word <= (cur_op == GET_CHAN) ? chan_count[chan_sel] : sample_word;
            end
            S_SHIFT:
            begin
                word <= {word[14:0], ser_bit};
                // Last word once the payload length is covered
                last_word <= bit_cnt + 1 >= payload_len;
            end
            S_PRESENT:
            begin
                rsp.data <= word;
                rsp.last <= last_word;
            end
            default:
            begin
            end
        endcase
    end

endmodule

//--- gps_corr_chan.sv
// Simplified correlator channel
`timescale 1ns/100ps

module gps_corr_chan (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sample,
    input  logic                                 hold,
    input  logic                                 resume,
    output logic                                 epoch,
    output logic [gps_cfg_pkg::GPS_REPL_BITS-1:0] replica,
    output logic [15:0]                          count
);
    import gps_cfg_pkg::*;

    logic [CODE_STAGES-1:0] lfsr;
    logic [CODE_STAGES-1:0] chip;
    logic [EPOCH_BITS-1:0]  epoch_cnt;
    logic [15:0] acc;
    logic held;
    logic step;
    logic wrap;
    logic code_bit;
    logic match;

    // Stage 5 is the code output
    assign code_bit = lfsr[CODE_STAGES-1];
    assign match    = sample == code_bit;
    assign step     = !held;
    // Last chip of the period
    assign wrap     = step && chip == CODE_STAGES'(CODE_LEN - 1);

    ////////////////////
    // Code generator and hold

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lfsr      <= CODE_SEED;
            chip      <= '0;
            epoch_cnt <= '0;
            acc       <= '0;
            held      <= 1'b0;
            epoch     <= 1'b0;
        end
        else
        begin
            epoch <= wrap;
            // A hold that meets a resume waits for the next one
            if (hold)
            begin
                held <= 1'b1;
            end
            else if (resume)
            begin
                held <= 1'b0;
            end
            if (wrap)
            begin
                lfsr      <= CODE_SEED;
                chip      <= '0;
                epoch_cnt <= epoch_cnt + 1'b1;
                acc       <= '0;
            end
            else if (step)
            begin
                // Feedback from taps 5 and 3
                lfsr <= {lfsr[CODE_STAGES-2:0], lfsr[4] ^ lfsr[2]};
                chip <= chip + 1'b1;
                acc  <= acc + match;
            end
        end
    end

    // Match count of the period just ended, with its last chip
    always_ff @(posedge clk)
    begin
        if (wrap)
        begin
            count <= acc + match;
        end
    end

    assign replica = {epoch_cnt, chip};

endmodule

//--- gps_sampler.sv
// Sample bit packer and word buffer
`timescale 1ns/100ps

module gps_sampler (
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_in,
    input  logic        pop,
    output logic        sample,
    output logic [15:0] word
);
    import gps_cfg_pkg::*;

    logic [15:0] buf_mem [SAMPLE_WORDS];
    logic [15:0] acc;
    logic [3:0]  bit_cnt;
    logic [SAMPLE_PTR_BITS-1:0] wr_ptr;
    logic [SAMPLE_PTR_BITS-1:0] rd_ptr;
    logic [SAMPLE_PTR_BITS:0]   fill;
    logic full;
    logic push;
    logic do_pop;

    // Registered sample, shared with the correlator channels
    always_ff @(posedge clk)
    begin
        sample <= sample_in;
    end

    assign full   = fill == (SAMPLE_PTR_BITS + 1)'(SAMPLE_WORDS);
    // Sixteenth bit completes a word
    assign push   = !full && bit_cnt == 4'hf;
    assign do_pop = pop && fill != '0;

    ////////////////////
    // Bit packing

    always_ff @(posedge clk)
    begin
        if (!full)
        begin
            acc <= {acc[14:0], sample};
        end
        if (push)
        begin
            buf_mem[wr_ptr] <= {acc[14:0], sample};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bit_cnt <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
        end
        else
        begin
            // Bits arriving while full are dropped
            if (!full)
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + push - do_pop;
        end
    end

    // Empty buffer reads as zero
    assign word = (fill == '0) ? 16'h0000 : buf_mem[rd_ptr];

endmodule

//--- gps_serial_shifter.sv
// Parallel load serial shifter
`timescale 1ns/100ps

module gps_serial_shifter #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     shift,
    input  payload_t din,
    output logic     sout
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] sr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sr <= '0;
        end
        else if (load)
        begin
            sr <= din;
        end
        else if (shift)
        begin
            // Zero fills from the bottom, so a read past the end pads zeros
            sr <= {sr[W-2:0], 1'b0};
        end
    end

    // MSB leaves first
    assign sout = sr[W-1];

endmodule

//--- gps_tick_timer.sv
// Tick counter and pause timer
`timescale 1ns/100ps

module gps_tick_timer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pause_load,
    input  logic [gps_cfg_pkg::PAUSE_BITS-1:0] pause_value,
    output logic [gps_cfg_pkg::TICK_BITS-1:0]  ticks,
    output logic                               resume
);
    import gps_cfg_pkg::*;

    logic [PAUSE_BITS-1:0] reload;
    logic [PAUSE_BITS-1:0] count;
    // Borrow out of the decrement marks the underflow
    logic [PAUSE_BITS:0]   dec;

    assign dec = {1'b0, count} - 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ticks  <= '0;
            reload <= '1;
            count  <= '1;
            resume <= 1'b0;
        end
        else
        begin
            // Free-running, one tick per clk
            ticks <= ticks + 1'b1;
            if (pause_load)
            begin
                reload <= pause_value;
                count  <= pause_value;
                resume <= 1'b0;
            end
            else if (dec[PAUSE_BITS])
            begin
                // Underflow, reload and release held channels
                count  <= reload;
                resume <= 1'b1;
            end
            else
            begin
                count  <= dec[PAUSE_BITS-1:0];
                resume <= 1'b0;
            end
        end
    end

endmodule

//--- gps_host_pkg.sv
// Host command and response types
package gps_host_pkg;

    // Write commands first, then reads
    typedef enum logic [3:0] {
        SET_CHAN,
        SET_MASK,
        SET_PAUSE,
        HOLD_CHAN,
        SAMPLER_RST,
        GET_SAMPLES,
        GET_SRQ,
        GET_SNAPSHOT,
        GET_CHAN
    } gps_op_e;

    typedef struct packed {
        gps_op_e     op;
        logic [15:0] arg;
    } gps_cmd_t;

    // One response word, last marks the end of a read
    typedef struct packed {
        logic [15:0] data;
        logic        last;
    } gps_rsp_t;

endpackage

//--- gps_cfg_pkg.sv
// Receiver geometry and payload types
package gps_cfg_pkg;

    // Channel geometry
    localparam int GPS_CHANS = 4;
    localparam int CHAN_SEL_BITS = $clog2(GPS_CHANS);
    localparam int GPS_REPL_BITS = 8;
    localparam int TICK_BITS = 48;
    localparam int PAUSE_BITS = 16;

    // 5-stage maximal code generator, taps 5 and 3
    localparam int CODE_STAGES = 5;
    localparam int CODE_LEN = 31;
    localparam logic [CODE_STAGES-1:0] CODE_SEED = '1;
    // Replica is epoch count above chip index
    localparam int EPOCH_BITS = GPS_REPL_BITS - CODE_STAGES;

    // Sampler buffer depth in 16-bit words
    localparam int SAMPLE_WORDS = 4;
    localparam int SAMPLE_PTR_BITS = $clog2(SAMPLE_WORDS);

    // Host request sits above the channel requests
    typedef struct packed {
        logic                 host;
        logic [GPS_CHANS-1:0] chan;
    } gps_srq_t;

    typedef struct packed {
        logic [TICK_BITS-1:0]                      ticks;
        logic [GPS_CHANS-1:0]                      epochs;
        logic [GPS_CHANS-1:0][GPS_REPL_BITS-1:0]   replicas;
    } gps_snap_t;

    // Serial payload lengths and read bit counter width
    localparam int SRQ_BITS = $bits(gps_srq_t);
    localparam int SNAP_BITS = $bits(gps_snap_t);
    localparam int READ_CNT_BITS = $clog2(SNAP_BITS + 16);

endpackage
